/* Makefile */
# Verilator build and run of the SPI card data path testbench

VERILATOR ?= verilator
TOP       ?= tb_spi_card
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_spi_card_table.svh */
// stimulus rows: data pattern, CRC corruption, check enable, expected flag and response kind
`ifndef TB_SPI_CARD_TABLE_SVH
`define TB_SPI_CARD_TABLE_SVH

// data pattern kinds
localparam logic [1:0] PAT_INC = 2'd0;
localparam logic [1:0] PAT_ZERO = 2'd1;
localparam logic [1:0] PAT_ONES = 2'd2;
localparam logic [1:0] PAT_RAND = 2'd3;

// response kinds
localparam logic RESP_ECHO = 1'b0;
localparam logic RESP_ERR = 1'b1;

typedef struct packed {
	logic [1:0] pattern;
	logic       corrupt;
	logic       check_en;
	logic       exp_crc_error;
	logic       exp_resp;
} stim_row_t;

localparam int NUM_ROWS = 9;

// pattern, corrupt CRC, crc_check_en, crc_error after block, response
localparam stim_row_t STIM_TABLE [NUM_ROWS] = '{
	'{PAT_INC,  1'b0, 1'b1, 1'b0, RESP_ECHO},
	'{PAT_INC,  1'b1, 1'b1, 1'b1, RESP_ERR},
	'{PAT_RAND, 1'b0, 1'b1, 1'b0, RESP_ECHO},
	'{PAT_RAND, 1'b1, 1'b0, 1'b0, RESP_ECHO},
	'{PAT_ZERO, 1'b0, 1'b1, 1'b0, RESP_ECHO},
	'{PAT_ONES, 1'b1, 1'b1, 1'b1, RESP_ERR},
	'{PAT_ONES, 1'b1, 1'b1, 1'b1, RESP_ERR},
	'{PAT_ONES, 1'b0, 1'b1, 1'b0, RESP_ECHO},
	'{PAT_RAND, 1'b0, 1'b1, 1'b0, RESP_ECHO}
};

`endif

/* bench/tb_spi_card.sv */
// testbench for the SPI card data path: clock, reset, host serializer, CRC model, checker
`timescale 1ns/1ps
`default_nettype none

module tb_spi_card;

	localparam int BLOCK_BYTES = 8;

	`include "tb_spi_card_table.svh"

	// three cycles per bit of headroom over every row
	localparam int TIMEOUT_CYCLES = NUM_ROWS * (BLOCK_BYTES + 6) * 8 * 3;

	logic clk;
	logic rst;
	logic datin;
	logic crc_check_en;
	logic dataout;
	logic crc_error;
	logic busy;

	integer seed;
	int errors;
	int cycle_cnt;

	spi_card_pkg::byte_t block [BLOCK_BYTES];
	logic host_bits [$];
	logic exp_bits [$];
	logic got_bits [$];

	spi_card_top #(.BLOCK_BYTES(BLOCK_BYTES)) DUT (
		.clk          (clk),
		.rst          (rst),
		.datin        (datin),
		.crc_check_en (crc_check_en),
		.dataout      (dataout),
		.crc_error    (crc_error),
		.busy         (busy)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// reference model and frame building
	////////////////////////////////////////////////////////////////////////////

	// one MSB-first step of the CCITT CRC16 without augmentation
	function automatic spi_card_pkg::crc16_t crc16_step(input spi_card_pkg::crc16_t crc,
		input logic b);
		logic fold;
		fold = crc[15] ^ b;
		crc16_step = {crc[14:0], 1'b0};
		if (fold)
			crc16_step = crc16_step ^ 16'h1021;
	endfunction

	task automatic queue_host_byte(input spi_card_pkg::byte_t b);
		for (int k = 7; k >= 0; k--)
			host_bits.push_back(b[k]);
	endtask

	task automatic queue_expected_byte(input spi_card_pkg::byte_t b);
		for (int k = 7; k >= 0; k--)
			exp_bits.push_back(b[k]);
	endtask

	task automatic build_frames(input stim_row_t row, input int r);
		spi_card_pkg::crc16_t crc;
		spi_card_pkg::crc16_t sent_crc;
		host_bits.delete();
		exp_bits.delete();
		crc = '0;
		for (int i = 0; i < BLOCK_BYTES; i++)
		begin
			case (row.pattern)
				PAT_INC: block[i] = spi_card_pkg::byte_t'(r * BLOCK_BYTES + i);
				PAT_ZERO: block[i] = 8'h00;
				PAT_ONES: block[i] = 8'hFF;
				default: block[i] = spi_card_pkg::byte_t'($random(seed));
			endcase
			for (int k = 7; k >= 0; k--)
				crc = crc16_step(crc, block[i][k]);
		end
		// flip a different CRC bit per row
		sent_crc = row.corrupt ? (crc ^ (16'h8000 >> (r % 16))) : crc;

		// idle, token, data, CRC
		repeat (4) host_bits.push_back(1'b1);
		queue_host_byte(8'hFE);
		for (int i = 0; i < BLOCK_BYTES; i++)
			queue_host_byte(block[i]);
		queue_host_byte(sent_crc[15:8]);
		queue_host_byte(sent_crc[7:0]);

		// echo carries a fresh CRC over the data
		if (row.exp_resp == RESP_ECHO)
		begin
			queue_expected_byte(8'hFE);
			for (int i = 0; i < BLOCK_BYTES; i++)
				queue_expected_byte(block[i]);
			queue_expected_byte(crc[15:8]);
			queue_expected_byte(crc[7:0]);
		end
		else
			queue_expected_byte(8'h0D);
		while (exp_bits.size() > 0 && exp_bits[0] == 1'b1)
			exp_bits.delete(0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_idle();
		if (dataout !== 1'b1 || busy !== 1'b0 || crc_error !== 1'b0)
		begin
			$display("[ERROR] t=%0t after reset dataout=%b busy=%b crc_error=%b",
				$time, dataout, busy, crc_error);
			errors++;
		end
	endtask

	task automatic run_row(input int r);
		stim_row_t row;
		logic seen_busy;
		logic done;
		logic flag_before;
		logic flag_wrong;
		int mismatches;
		row = STIM_TABLE[r];
		build_frames(row, r);
		got_bits.delete();
		seen_busy = 1'b0;
		done = 1'b0;
		flag_wrong = 1'b0;
		mismatches = 0;
		// flag of the previous row holds until the token unless checking is off
		flag_before = 1'b0;
		if (r > 0)
			flag_before = STIM_TABLE[r - 1].exp_crc_error & row.check_en;
		@(negedge clk);
		crc_check_en = row.check_en;
		// sample first, then drive the next host bit
		while (!done)
		begin
			@(negedge clk);
			if (busy)
			begin
				if (!seen_busy && crc_error)
				begin
					$display("[ERROR] t=%0t row %0d crc_error not cleared at start token",
						$time, r);
					errors++;
				end
				seen_busy = 1'b1;
				got_bits.push_back(dataout);
			end
			else if (!seen_busy)
			begin
				if (crc_error !== flag_before && !flag_wrong)
				begin
					$display("[ERROR] t=%0t row %0d crc_error=%b before start token, expected %b",
						$time, r, crc_error, flag_before);
					errors++;
					flag_wrong = 1'b1;
				end
			end
			else if (host_bits.size() == 0)
				done = 1'b1;
			if (host_bits.size() > 0)
				datin = host_bits.pop_front();
			else
				datin = 1'b1;
		end

		if (crc_error !== row.exp_crc_error)
		begin
			$display("[ERROR] t=%0t row %0d crc_error=%b expected %b",
				$time, r, crc_error, row.exp_crc_error);
			errors++;
		end

		while (got_bits.size() > 0 && got_bits[0] == 1'b1)
			got_bits.delete(0);
		if (got_bits.size() != exp_bits.size())
		begin
			$display("[ERROR] t=%0t row %0d response has %0d bits, expected %0d",
				$time, r, got_bits.size(), exp_bits.size());
			errors++;
		end
		else
		begin
			for (int i = 0; i < exp_bits.size(); i++)
			begin
				if (got_bits[i] !== exp_bits[i])
					mismatches++;
			end
			if (mismatches != 0)
			begin
				$display("[ERROR] t=%0t row %0d response differs in %0d bits",
					$time, r, mismatches);
				errors++;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		datin = 1'b1;
		crc_check_en = 1'b1;
		seed = 32'h28bfdd1a;
		errors = 0;
		cycle_cnt = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_idle();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("rows run: %0d, errors: %0d", NUM_ROWS, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+bench
design/spi_card_pkg.sv
design/spi_crc16.sv
design/spi_data_line.sv
design/spi_data_rx.sv
design/spi_block_buffer.sv
design/spi_data_tx.sv
design/spi_card_top.sv
bench/tb_spi_card.sv

/* design/spi_block_buffer.sv */
// one-block store between receive and transmit, with block status and drain sequencing
`timescale 1ns/1ps
`default_nettype none

module spi_block_buffer #(
	parameter int BLOCK_BYTES = 8
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                rx_req,
	output logic                rx_ack,
	input  spi_card_pkg::byte_t rx_byte,
	input  logic                rx_end,
	input  logic                rx_bad,
	output logic                tx_req,
	input  logic                tx_ack,
	output spi_card_pkg::byte_t tx_byte,
	output logic                tx_last,
	output logic                tx_bad
);

	localparam int IDX_W = $clog2(BLOCK_BYTES);

	spi_card_pkg::byte_t mem [BLOCK_BYTES];
	logic [IDX_W-1:0] wr_idx;
	logic [IDX_W-1:0] rd_idx;
	logic draining;
	logic bad;
	logic rx_take;

	// nothing new from rx until the block has left
	assign rx_take = rx_req && !rx_ack && !draining;

	// a bad block is a single item
	assign tx_byte = mem[rd_idx];
	assign tx_bad = bad;
	assign tx_last = bad || (rd_idx == IDX_W'(BLOCK_BYTES - 1));

	always_ff @(posedge clk)
	begin
		if (rx_take && !rx_end)
			mem[wr_idx] <= rx_byte;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rx_ack <= 1'b0;
			tx_req <= 1'b0;
			wr_idx <= '0;
			rd_idx <= '0;
			draining <= 1'b0;
			bad <= 1'b0;
		end
		else
		begin
			////////////////////////////////////////////////////////////////////////////
			// fill side
			////////////////////////////////////////////////////////////////////////////
			if (rx_take)
			begin
				rx_ack <= 1'b1;
				if (rx_end)
				begin
					bad <= rx_bad;
					draining <= 1'b1;
					wr_idx <= '0;
					rd_idx <= '0;
				end
				else
					wr_idx <= wr_idx + 1'b1;
			end
			else if (!rx_req && rx_ack)
				rx_ack <= 1'b0;

			////////////////////////////////////////////////////////////////////////////
			// drain side
			////////////////////////////////////////////////////////////////////////////
			if (draining && !tx_req && !tx_ack)
				tx_req <= 1'b1;
			else if (tx_req && tx_ack)
			begin
				tx_req <= 1'b0;
				if (tx_last)
					draining <= 1'b0;
				else
					rd_idx <= rd_idx + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/spi_card_pkg.sv */
// data byte, CRC and bit index types, block tokens, CRC polynomial, rx and tx FSM states
`default_nettype none

package spi_card_pkg;

	// one byte on the data line, sent MSB first
	typedef logic [7:0] byte_t;

	// CRC16 remainder
	typedef logic [15:0] crc16_t;

	// bit position within a byte
	typedef logic [2:0] bit_cnt_t;

	////////////////////////////////////////////////////////////////////////////
	// tokens and polynomial
	////////////////////////////////////////////////////////////////////////////

	localparam byte_t START_TOKEN = 8'hFE;
	localparam byte_t DATA_ERR_TOKEN = 8'h0D;

	// CCITT, x^16 + x^12 + x^5 + 1
	localparam crc16_t CRC_POLY = 16'h1021;

	////////////////////////////////////////////////////////////////////////////
	// FSM states
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		rx_hunt,
		rx_data,
		rx_crc,
		rx_push_end
	} rx_state_t;

	typedef enum logic [2:0] {
		tx_idle,
		tx_token,
		tx_data,
		tx_crc,
		tx_err
	} tx_state_t;

endpackage

`default_nettype wire

/* design/spi_card_top.sv */
// SPI card data path top: data line, receive stage, block buffer, transmit stage
`timescale 1ns/1ps
`default_nettype none

module spi_card_top #(
	parameter int BLOCK_BYTES = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic datin,
	input  logic crc_check_en,
	output logic dataout,
	output logic crc_error,
	output logic busy
);

	logic rcvd_data;
	logic crc_clr;
	logic rd_data;
	logic rd_crc;
	logic wr_data;
	logic wr_crc;
	logic xmit_data;
	logic busy_rx;
	logic busy_tx;

	// rx to buffer
	logic rx_req;
	logic rx_ack;
	spi_card_pkg::byte_t rx_byte;
	logic rx_end;
	logic rx_bad;

	// buffer to tx
	logic tx_req;
	logic tx_ack;
	spi_card_pkg::byte_t tx_byte;
	logic tx_last;
	logic tx_bad;

	// held from token detection through the end of the response
	assign busy = busy_rx | busy_tx;

	spi_data_line u_line (
		.clk          (clk),
		.rst          (rst),
		.datin        (datin),
		.crc_check_en (crc_check_en),
		.crc_clr      (crc_clr),
		.rd_data      (rd_data),
		.rd_crc       (rd_crc),
		.wr_data      (wr_data),
		.wr_crc       (wr_crc),
		.xmit_data    (xmit_data),
		.rcvd_data    (rcvd_data),
		.dataout      (dataout),
		.crc_error    (crc_error)
	);

	spi_data_rx #(.BLOCK_BYTES(BLOCK_BYTES)) u_rx (
		.clk       (clk),
		.rst       (rst),
		.rcvd_data (rcvd_data),
		.crc_error (crc_error),
		.crc_clr   (crc_clr),
		.rd_data   (rd_data),
		.rd_crc    (rd_crc),
		.rx_req    (rx_req),
		.rx_ack    (rx_ack),
		.rx_byte   (rx_byte),
		.rx_end    (rx_end),
		.rx_bad    (rx_bad),
		.busy_rx   (busy_rx)
	);

	spi_block_buffer #(.BLOCK_BYTES(BLOCK_BYTES)) u_buf (
		.clk     (clk),
		.rst     (rst),
		.rx_req  (rx_req),
		.rx_ack  (rx_ack),
		.rx_byte (rx_byte),
		.rx_end  (rx_end),
		.rx_bad  (rx_bad),
		.tx_req  (tx_req),
		.tx_ack  (tx_ack),
		.tx_byte (tx_byte),
		.tx_last (tx_last),
		.tx_bad  (tx_bad)
	);

	spi_data_tx #(.BLOCK_BYTES(BLOCK_BYTES)) u_tx (
		.clk       (clk),
		.rst       (rst),
		.tx_req    (tx_req),
		.tx_ack    (tx_ack),
		.tx_byte   (tx_byte),
		.tx_last   (tx_last),
		.tx_bad    (tx_bad),
		.wr_data   (wr_data),
		.wr_crc    (wr_crc),
		.xmit_data (xmit_data),
		.busy_tx   (busy_tx)
	);

endmodule

`default_nettype wire

/* design/spi_crc16.sv */
// serial CRC16 generator with MSB-first remainder shift-out
`timescale 1ns/1ps
`default_nettype none

module spi_crc16 (
	input  logic clk,
	input  logic rst,
	input  logic clr,
	input  logic gen_en,
	input  logic out_en,
	input  logic din,
	output logic dout
);

	spi_card_pkg::crc16_t crc_reg;
	logic fb;

	// top remainder bit against the incoming bit
	assign fb = crc_reg[15] ^ din;

	// remainder leaves MSB first
	assign dout = crc_reg[15];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			crc_reg <= '0;
		else if (clr)
			crc_reg <= '0;
		else if (gen_en)
			crc_reg <= {crc_reg[14:0], 1'b0} ^ (fb ? spi_card_pkg::CRC_POLY : '0);
		else if (out_en)
			// zero fill, so a full shift-out leaves a cleared register
			crc_reg <= {crc_reg[14:0], 1'b0};
	end

	// the unit serves one direction at a time, either summing or emitting
	gen_out_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(gen_en && out_en)
	);

endmodule

`default_nettype wire

/* design/spi_data_line.sv */
// data line: input sampling, shared CRC muxing, output bit select, sticky CRC error flag
`timescale 1ns/1ps
`default_nettype none

module spi_data_line (
	input  logic clk,
	input  logic rst,
	input  logic datin,
	input  logic crc_check_en,
	input  logic crc_clr,
	input  logic rd_data,
	input  logic rd_crc,
	input  logic wr_data,
	input  logic wr_crc,
	input  logic xmit_data,
	output logic rcvd_data,
	output logic dataout,
	output logic crc_error
);

	logic crc_din;
	logic crc_dout;
	logic gen_en;
	logic out_en;

	////////////////////////////////////////////////////////////////////////////
	// CRC source and output select
	////////////////////////////////////////////////////////////////////////////

	// transmit data feeds the CRC only while bytes go out
	assign crc_din = wr_data ? xmit_data : rcvd_data;
	assign gen_en = rd_data | wr_data;
	assign out_en = rd_crc | wr_crc;

	// card drives its own CRC bits, everything else comes from tx
	assign dataout = wr_crc ? crc_dout : xmit_data;

	// line idles high
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			rcvd_data <= 1'b1;
		else
			rcvd_data <= datin;
	end

	// sticky until the next start token
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			crc_error <= 1'b0;
		else if (!crc_check_en || crc_clr)
			crc_error <= 1'b0;
		else if (rd_crc && (crc_dout != rcvd_data))
			crc_error <= 1'b1;
	end

	spi_crc16 u_crc (
		.clk    (clk),
		.rst    (rst),
		.clr    (crc_clr),
		.gen_en (gen_en),
		.out_en (out_en),
		.din    (crc_din),
		.dout   (crc_dout)
	);

	// half duplex, rx and tx never own the line together
	half_duplex: assert property (
		@(posedge clk) disable iff (rst)
		!((rd_data || rd_crc) && (wr_data || wr_crc))
	);

endmodule

`default_nettype wire

/* design/spi_data_rx.sv */
// receive stage: start token hunt, byte assembly, CRC window, byte and end-item handshake
`timescale 1ns/1ps
`default_nettype none

module spi_data_rx #(
	parameter int BLOCK_BYTES = 8
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                rcvd_data,
	input  logic                crc_error,
	output logic                crc_clr,
	output logic                rd_data,
	output logic                rd_crc,
	output logic                rx_req,
	input  logic                rx_ack,
	output spi_card_pkg::byte_t rx_byte,
	output logic                rx_end,
	output logic                rx_bad,
	output logic                busy_rx
);

	localparam int IDX_W = $clog2(BLOCK_BYTES);

	spi_card_pkg::rx_state_t state;
	spi_card_pkg::byte_t window;
	spi_card_pkg::byte_t next_window;
	spi_card_pkg::bit_cnt_t bit_cnt;
	logic [3:0] crc_cnt;
	logic [IDX_W-1:0] byte_idx;
	logic token_hit;
	logic byte_done;

	assign next_window = {window[6:0], rcvd_data};
	assign token_hit = (state == spi_card_pkg::rx_hunt) &&
		(next_window == spi_card_pkg::START_TOKEN);
	assign byte_done = (state == spi_card_pkg::rx_data) && (bit_cnt == 3'd7);

	// CRC clears on the token so the first data bit is summed next cycle
	assign crc_clr = token_hit;
	assign rd_data = (state == spi_card_pkg::rx_data);
	assign rd_crc = (state == spi_card_pkg::rx_crc);
	assign busy_rx = (state != spi_card_pkg::rx_hunt);

	// byte goes out on the cycle its last bit arrives
	always_ff @(posedge clk)
	begin
		if (byte_done)
			rx_byte <= next_window;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= spi_card_pkg::rx_hunt;
			window <= '1;
			bit_cnt <= '0;
			crc_cnt <= '0;
			byte_idx <= '0;
			rx_req <= 1'b0;
			rx_end <= 1'b0;
			rx_bad <= 1'b0;
		end
		else
		begin
			window <= next_window;
			// retire a handshake once the buffer answers
			if (rx_req && rx_ack)
			begin
				rx_req <= 1'b0;
				rx_end <= 1'b0;
			end
			case (state)
				spi_card_pkg::rx_hunt:
				begin
					bit_cnt <= '0;
					byte_idx <= '0;
					if (token_hit)
						state <= spi_card_pkg::rx_data;
				end
				spi_card_pkg::rx_data:
				begin
					bit_cnt <= bit_cnt + 3'd1;
					if (byte_done)
					begin
						rx_req <= 1'b1;
						if (byte_idx == IDX_W'(BLOCK_BYTES - 1))
						begin
							crc_cnt <= '0;
							state <= spi_card_pkg::rx_crc;
						end
						else
							byte_idx <= byte_idx + 1'b1;
					end
				end
				spi_card_pkg::rx_crc:
				begin
					crc_cnt <= crc_cnt + 4'd1;
					if (crc_cnt == 4'd15)
						state <= spi_card_pkg::rx_push_end;
				end
				default:
				begin
					// error flag has settled one cycle after the last CRC bit
					if (!rx_req && !rx_ack)
					begin
						rx_req <= 1'b1;
						rx_end <= 1'b1;
						rx_bad <= crc_error;
					end
					else if (rx_req && rx_ack)
						state <= spi_card_pkg::rx_hunt;
				end
			endcase
		end
	end

	// buffer must have closed the last four-phase cycle before a new byte is offered
	req_after_idle: assert property (
		@(posedge clk) disable iff (rst)
		$rose(rx_req) |-> !rx_ack
	);

endmodule

`default_nettype wire

/* design/spi_data_tx.sv */
// transmit stage: start token, buffered bytes, CRC window, or the data error token
`timescale 1ns/1ps
`default_nettype none

module spi_data_tx #(
	parameter int BLOCK_BYTES = 8
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                tx_req,
	output logic                tx_ack,
	input  spi_card_pkg::byte_t tx_byte,
	input  logic                tx_last,
	input  logic                tx_bad,
	output logic                wr_data,
	output logic                wr_crc,
	output logic                xmit_data,
	output logic                busy_tx
);

	localparam int IDX_W = $clog2(BLOCK_BYTES);

	spi_card_pkg::tx_state_t state;
	spi_card_pkg::byte_t sh;
	spi_card_pkg::byte_t nxt;
	spi_card_pkg::bit_cnt_t bit_cnt;
	logic [3:0] crc_cnt;
	logic [IDX_W-1:0] sent_cnt;
	logic have;
	logic nxt_last;
	logic cur_last;
	logic take;

	// one byte of lookahead, fetched while the current byte shifts
	assign take = tx_req && !tx_ack && !have;

	assign wr_data = (state == spi_card_pkg::tx_data);
	assign wr_crc = (state == spi_card_pkg::tx_crc);
	assign xmit_data = ((state == spi_card_pkg::tx_idle) || (state == spi_card_pkg::tx_crc)) ?
		1'b1 : sh[7];
	// tx_req covers the hand-over gap from the buffer
	assign busy_tx = (state != spi_card_pkg::tx_idle) || tx_req;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= spi_card_pkg::tx_idle;
			tx_ack <= 1'b0;
			sh <= '0;
			nxt <= '0;
			bit_cnt <= '0;
			crc_cnt <= '0;
			sent_cnt <= '0;
			have <= 1'b0;
			nxt_last <= 1'b0;
			cur_last <= 1'b0;
		end
		else
		begin
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
			if (take)
			begin
				tx_ack <= 1'b1;
				sent_cnt <= (state == spi_card_pkg::tx_idle) ? IDX_W'(1) : sent_cnt + 1'b1;
				if (!tx_bad)
				begin
					nxt <= tx_byte;
					nxt_last <= tx_last;
					have <= 1'b1;
				end
			end
			case (state)
				spi_card_pkg::tx_idle:
				begin
					bit_cnt <= '0;
					cur_last <= 1'b0;
					// token waits until the first byte is in hand
					if (take)
					begin
						if (tx_bad)
						begin
							sh <= spi_card_pkg::DATA_ERR_TOKEN;
							state <= spi_card_pkg::tx_err;
						end
						else
						begin
							sh <= spi_card_pkg::START_TOKEN;
							state <= spi_card_pkg::tx_token;
						end
					end
				end
				spi_card_pkg::tx_token, spi_card_pkg::tx_data:
				begin
					sh <= {sh[6:0], 1'b0};
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
					begin
						if ((state == spi_card_pkg::tx_data) && cur_last)
						begin
							crc_cnt <= '0;
							state <= spi_card_pkg::tx_crc;
						end
						else
						begin
							sh <= nxt;
							cur_last <= nxt_last;
							have <= 1'b0;
							state <= spi_card_pkg::tx_data;
						end
					end
				end
				spi_card_pkg::tx_crc:
				begin
					crc_cnt <= crc_cnt + 4'd1;
					if (crc_cnt == 4'd15)
						state <= spi_card_pkg::tx_idle;
				end
				default:
				begin
					sh <= {sh[6:0], 1'b0};
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7)
						state <= spi_card_pkg::tx_idle;
				end
			endcase
		end
	end

	// buffer refills the lookahead within one byte time, so no gap inside a block
	no_underrun: assert property (
		@(posedge clk) disable iff (rst)
		(state == spi_card_pkg::tx_data) && (bit_cnt == 3'd7) && !cur_last |-> have
	);

	// last flag from the buffer lands on the final byte of the block
	last_on_count: assert property (
		@(posedge clk) disable iff (rst)
		take && tx_last && !tx_bad && (state != spi_card_pkg::tx_idle)
			|-> (sent_cnt == IDX_W'(BLOCK_BYTES - 1))
	);

endmodule

`default_nettype wire
